/* verilog.f */
+incdir+verification
hw/kd_tree_pkg.sv
hw/kd_node_table.sv
hw/kd_level_stage.sv
hw/kd_tree_search.sv
verification/kd_tree_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the k-d tree testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module kd_tree_tb \
  > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vkd_tree_tb > sim.log 2>&1 \
  || { cat sim.log; echo "simulator exited with an error"; exit 1; }

cat sim.log

grep -q "TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "no pass message in the log"; exit 1; }
echo "simulation passed"

/* verification/kd_tree_model.svh */
// k-d tree reference model for the testbench
// keeps node words in load order and descends a patch level by level,
// equal components going to the right child

`ifndef KD_TREE_MODEL_SVH
`define KD_TREE_MODEL_SVH

// node words in breadth-first order, index n has children 2n+1 and 2n+2
logic [kd_tree_pkg::node_word_width-1:0] tree_nodes [kd_tree_pkg::node_count];
int nodes_written = 0;

// empty tree, every word zero as after reset
function automatic void clear_tree();
  for (int n = 0; n < kd_tree_pkg::node_count; n++) begin
    tree_nodes[n] = '0;
  end
  nodes_written = 0;
endfunction

// sequential load, words past the last node are dropped
function automatic void store_node_word(input logic [kd_tree_pkg::node_word_width-1:0] word);
  if (nodes_written < kd_tree_pkg::node_count) begin
    tree_nodes[nodes_written] = word;
    nodes_written++;
  end
endfunction

// walk from the root through all internal levels, return the leaf number
function automatic int descend_tree(input logic [kd_tree_pkg::patch_width-1:0] p);
  int idx;
  int dim;
  int value;
  int comp;
  idx = 0;
  for (int lvl = 0; lvl < kd_tree_pkg::tree_depth; lvl++) begin
    dim   = int'(tree_nodes[idx][kd_tree_pkg::split_dim_lsb +: kd_tree_pkg::split_dim_width]);
    value = int'(tree_nodes[idx][kd_tree_pkg::split_value_lsb +: kd_tree_pkg::component_width]);
    comp  = int'(p[dim * kd_tree_pkg::component_width +: kd_tree_pkg::component_width]);
    if (comp >= value) begin
      idx = 2 * idx + 2;
    end else begin
      idx = 2 * idx + 1;
    end
  end
  // leaves follow the 127 internal nodes
  return idx - kd_tree_pkg::node_count;
endfunction

`endif

/* verification/kd_tree_tb.sv */
// k-d tree search engine testbench
// loads a random tree, streams random and boundary patches through the
// pipeline and checks every leaf result against the reference model

`timescale 1ns/1ps
`default_nettype none

module kd_tree_tb;

  localparam int seed        = 83;
  localparam int half_period = 10;
  localparam int query_count = 300;
  localparam int tie_count   = 20;

  logic                                      clk;
  logic                                      rst_n;
  logic                                      load_en;
  logic [kd_tree_pkg::node_word_width-1:0]   load_word;
  logic                                      load_full;
  logic                                      query_valid;
  logic [kd_tree_pkg::patch_width-1:0]       patch;
  logic                                      leaf_valid;
  logic [kd_tree_pkg::leaf_index_width-1:0]  leaf_index;

  // xorshift state
  logic [31:0] rng_state;

  // scoreboard, expected leaf and the edge that sampled the query
  int expected_leaf [$];
  int issue_edge [$];

  int cycle_count = 0;
  int mismatch_count = 0;
  int failure_count = 0;
  int queries_issued = 0;
  int results_seen = 0;
  bit full_seen = 1'b0;

  `include "kd_tree_model.svh"

  kd_tree_search u_kd_tree_search (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en     (load_en),
    .load_word   (load_word),
    .load_full   (load_full),
    .query_valid (query_valid),
    .patch       (patch),
    .leaf_valid  (leaf_valid),
    .leaf_index  (leaf_index)
  );

  always #half_period clk = ~clk;

  // posedge counter, edge numbers tag the queries
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [kd_tree_pkg::patch_width-1:0] random_patch();
    logic [63:0] r;
    r = {next_random(), next_random()};
    return r[kd_tree_pkg::patch_width-1:0];
  endfunction

  // force the visited component to the split value wherever that component
  // is still free, so the path meets as many ties as possible
  function automatic logic [kd_tree_pkg::patch_width-1:0] make_tie_patch(
    input logic [kd_tree_pkg::patch_width-1:0] base
  );
    logic [kd_tree_pkg::patch_width-1:0] p;
    logic [kd_tree_pkg::patch_dims-1:0]  forced;
    int idx;
    int dim;
    logic [kd_tree_pkg::component_width-1:0] value;
    p = base;
    forced = '0;
    idx = 0;
    for (int lvl = 0; lvl < kd_tree_pkg::tree_depth; lvl++) begin
      dim   = int'(tree_nodes[idx][kd_tree_pkg::split_dim_lsb +: kd_tree_pkg::split_dim_width]);
      value = tree_nodes[idx][kd_tree_pkg::split_value_lsb +: kd_tree_pkg::component_width];
      if (!forced[dim]) begin
        p[dim * kd_tree_pkg::component_width +: kd_tree_pkg::component_width] = value;
        forced[dim] = 1'b1;
      end
      if (p[dim * kd_tree_pkg::component_width +: kd_tree_pkg::component_width] >= value) begin
        idx = 2 * idx + 2;
      end else begin
        idx = 2 * idx + 1;
      end
    end
    return p;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      mismatch_count++;
      $display("Error at %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
    end
  endtask

  // one node write, then gap idle cycles
  task automatic write_node_word(input logic [kd_tree_pkg::node_word_width-1:0] word,
                                 input int gap);
    @(negedge clk);
    check_value("load_full", int'(nodes_written == kd_tree_pkg::node_count), int'(load_full));
    load_en   = 1'b1;
    load_word = word;
    store_node_word(word);
    repeat (gap) begin
      @(negedge clk);
      load_en = 1'b0;
    end
  endtask

  task automatic wait_load_full(input int limit);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      load_en = 1'b0;
      waited++;
    end while (!load_full && waited < limit);
    if (!load_full) begin
      failure_count++;
      $display("load_full did not rise within %0d cycles of the last node write", limit);
    end else begin
      check_value("load_full_delay", 1, waited);
      full_seen = 1'b1;
    end
  endtask

  task automatic issue_query(input logic [kd_tree_pkg::patch_width-1:0] p);
    @(negedge clk);
    query_valid = 1'b1;
    patch       = p;
    // sampled by the coming posedge
    expected_leaf.push_back(descend_tree(p));
    issue_edge.push_back(cycle_count + 1);
    queries_issued++;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      query_valid = 1'b0;
      load_en     = 1'b0;
    end
  endtask

  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    while (expected_leaf.size() > 0 && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (expected_leaf.size() > 0) begin
      failure_count++;
      $display("%0d results still outstanding after %0d cycles", expected_leaf.size(), limit);
    end
  endtask

  // result monitor, outputs come from registers so the falling edge is safe
  // stage 0 loads on the sampling edge, so the seventh stage register
  // holds the result tree_depth-1 edges after it
  always @(negedge clk) begin
    if (rst_n) begin
      if (full_seen && !load_full) begin
        failure_count++;
        $display("load_full dropped at %0t ns after the table was full", $time);
      end
      if (leaf_valid) begin
        if (expected_leaf.size() == 0) begin
          failure_count++;
          $display("leaf_valid pulsed at %0t ns with no query in flight", $time);
        end else begin
          check_value("leaf_valid_cycle", issue_edge[0] + kd_tree_pkg::tree_depth - 1,
                      cycle_count);
          check_value("leaf_index", expected_leaf[0], int'(leaf_index));
          void'(expected_leaf.pop_front());
          void'(issue_edge.pop_front());
          results_seen++;
        end
      end else if (expected_leaf.size() > 0 &&
                   issue_edge[0] + kd_tree_pkg::tree_depth - 1 <= cycle_count) begin
        failure_count++;
        $display("no leaf_valid at %0t ns for the query sampled on edge %0d",
                 $time, issue_edge[0]);
        void'(expected_leaf.pop_front());
        void'(issue_edge.pop_front());
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [kd_tree_pkg::node_word_width-1:0] word;
    int gap;
    clk         = 1'b0;
    rst_n       = 1'b0;
    load_en     = 1'b0;
    load_word   = '0;
    query_valid = 1'b0;
    patch       = '0;
    rng_state   = 32'(seed);
    clear_tree();

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("leaf_valid", 0, int'(leaf_valid));
    check_value("load_full", 0, int'(load_full));

    // random tree, dimension kept below patch_dims
    for (int n = 0; n < kd_tree_pkg::node_count; n++) begin
      r = next_random();
      word[kd_tree_pkg::split_value_lsb +: kd_tree_pkg::component_width] =
        r[kd_tree_pkg::component_width-1:0];
      word[kd_tree_pkg::split_dim_lsb +: kd_tree_pkg::split_dim_width] =
        kd_tree_pkg::split_dim_width'(r[31:16] % kd_tree_pkg::patch_dims);
      gap = (n == kd_tree_pkg::node_count - 1) ? 0 : int'(next_random() % 3);
      write_node_word(word, gap);
    end
    wait_load_full(4);

    // writes into a full table must leave the tree alone
    for (int n = 0; n < 3; n++) begin
      r = next_random();
      write_node_word(r[kd_tree_pkg::node_word_width-1:0], 1);
    end

    // random patches, bursts mixed with idle gaps
    for (int q = 0; q < query_count; q++) begin
      issue_query(random_patch());
      r = next_random();
      if (r[1:0] == 2'b00) begin
        idle_cycles(1 + int'(r[5:4]));
      end
    end

    // ties at as many levels as possible, back to back
    for (int q = 0; q < tie_count; q++) begin
      issue_query(make_tie_patch(random_patch()));
    end
    issue_query('0);
    issue_query('1);
    idle_cycles(1);

    wait_drain(40);
    // quiet pipeline, any late pulse is spurious
    idle_cycles(12);

    check_value("result_count", queries_issued, results_seen);
    $display("error counts: %0d value mismatches, %0d other failures, %0d of %0d results seen",
             mismatch_count, failure_count, results_seen, queries_issued);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/kd_tree_search.sv */
// k-d tree search engine top
// node table plus a chain of seven level stages, one query per clock,
// leaf index out a fixed seven cycles after the query

`timescale 1ns/1ps
`default_nettype none

module kd_tree_search (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      load_en,
  input  logic [kd_tree_pkg::node_word_width-1:0]   load_word,
  output logic                                      load_full,
  input  logic                                      query_valid,
  input  logic [kd_tree_pkg::patch_width-1:0]       patch,
  output logic                                      leaf_valid,
  output logic [kd_tree_pkg::leaf_index_width-1:0]  leaf_index
);

  // pipeline links, entry l feeds stage l, entry tree_depth is the result
  logic [kd_tree_pkg::tree_depth:0]                                  stage_valid;
  logic [kd_tree_pkg::tree_depth:0][kd_tree_pkg::patch_width-1:0]    stage_patch;
  logic [kd_tree_pkg::tree_depth:0][kd_tree_pkg::node_index_width:0] stage_index;

  // table read ports, one per level
  logic [kd_tree_pkg::tree_depth-1:0][kd_tree_pkg::node_index_width-1:0] read_index;
  logic [kd_tree_pkg::tree_depth-1:0][kd_tree_pkg::node_word_width-1:0]  read_word;

  // final child index with the internal node offset removed
  logic [kd_tree_pkg::node_index_width:0] leaf_offset;

  // every query starts at the root
  assign stage_valid[0] = query_valid;
  assign stage_patch[0] = patch;
  assign stage_index[0] = '0;

  kd_node_table u_node_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_en    (load_en),
    .load_word  (load_word),
    .load_full  (load_full),
    .read_index (read_index),
    .read_word  (read_word)
  );

  for (genvar l = 0; l < kd_tree_pkg::tree_depth; l++) begin : g_level
    // children above level 5 still fit 7 bits, only the last stage needs 8
    kd_level_stage #(
      .level (l)
    ) u_level_stage (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (stage_valid[l]),
      .in_patch   (stage_patch[l]),
      .in_index   (stage_index[l][kd_tree_pkg::node_index_width-1:0]),
      .node_index (read_index[l]),
      .node_word  (read_word[l]),
      .out_valid  (stage_valid[l+1]),
      .out_patch  (stage_patch[l+1]),
      .out_index  (stage_index[l+1])
    );
  end

  // leaves are numbered 127 upward in the child index space
  assign leaf_offset = stage_index[kd_tree_pkg::tree_depth] -
                       (kd_tree_pkg::node_index_width + 1)'(kd_tree_pkg::node_count);

  assign leaf_valid = stage_valid[kd_tree_pkg::tree_depth];
  assign leaf_index = leaf_offset[kd_tree_pkg::leaf_index_width-1:0];

endmodule

`default_nettype wire

/* hw/kd_level_stage.sv */
// k-d tree level stage
// picks the patch component named by the node's split dimension, compares it
// against the split value and registers the child index for the next level

`timescale 1ns/1ps
`default_nettype none

module kd_level_stage #(
  parameter int level = 0
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      in_valid,
  input  logic [kd_tree_pkg::patch_width-1:0]       in_patch,
  input  logic [kd_tree_pkg::node_index_width-1:0]  in_index,
  output logic [kd_tree_pkg::node_index_width-1:0]  node_index,
  input  logic [kd_tree_pkg::node_word_width-1:0]   node_word,
  output logic                                      out_valid,
  output logic [kd_tree_pkg::patch_width-1:0]       out_patch,
  output logic [kd_tree_pkg::node_index_width:0]    out_index
);

  // fields of the node being visited
  logic [kd_tree_pkg::split_dim_width-1:0] split_dim;
  logic [kd_tree_pkg::component_width-1:0] split_value;

  // selected patch component
  logic [kd_tree_pkg::component_width-1:0] component;

  // comparison result and next node
  logic                                    go_right;
  logic [kd_tree_pkg::node_index_width:0]  child_index;

  // ask the table for the node this patch is at
  assign node_index = in_index;

  assign split_dim   = node_word[kd_tree_pkg::split_dim_lsb +: kd_tree_pkg::split_dim_width];
  assign split_value = node_word[kd_tree_pkg::split_value_lsb +: kd_tree_pkg::component_width];

  // component mux over the patch dimensions
  // out of range dimension yields zero
  always_comb begin
    component = '0;
    for (int d = 0; d < kd_tree_pkg::patch_dims; d++) begin
      if (int'(split_dim) == d) begin
        component = in_patch[d * kd_tree_pkg::component_width +: kd_tree_pkg::component_width];
      end
    end
  end

  // ties go right
  assign go_right = (component >= split_value);

  // left child 2n+1, right child 2n+2
  assign child_index = {in_index, 1'b0} + (go_right ? 8'd2 : 8'd1);

  // valid travels with reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // patch and index ride along with valid
  always_ff @(posedge clk) begin
    out_patch <= in_patch;
    out_index <= child_index;
  end

  // the previous stage must have handed over a node of this level,
  // nodes of level l are 2**l-1 up to 2**(l+1)-2
  a_index_in_level : assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> ((int'(in_index) >= (1 << level) - 1) &&
                  (int'(in_index) <= (1 << (level + 1)) - 2))
  ) else $error("level %0d stage got node index %0d", level, in_index);

endmodule

`default_nettype wire

/* hw/kd_node_table.sv */
// k-d tree node table
// holds the 127 internal node words, filled in breadth-first order through
// an internal write counter, and serves one combinational read per tree level

`timescale 1ns/1ps
`default_nettype none

module kd_node_table (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       load_en,
  input  logic [kd_tree_pkg::node_word_width-1:0]    load_word,
  output logic                                       load_full,
  input  logic [kd_tree_pkg::tree_depth-1:0][kd_tree_pkg::node_index_width-1:0] read_index,
  output logic [kd_tree_pkg::tree_depth-1:0][kd_tree_pkg::node_word_width-1:0]  read_word
);

  // node storage, index n is breadth-first position
  logic [kd_tree_pkg::node_word_width-1:0] nodes [kd_tree_pkg::node_count];

  // next slot to be written, stops at node_count
  logic [kd_tree_pkg::node_index_width-1:0] node_count_q;

  // accepted write strobe
  logic wr_en;

  // split dimension field of the incoming word
  logic [kd_tree_pkg::split_dim_width-1:0] load_dim;

  // full once every node slot has been written
  assign load_full = (node_count_q ==
                      kd_tree_pkg::node_index_width'(kd_tree_pkg::node_count));

  // writes past full are dropped
  assign wr_en = load_en && !load_full;

  assign load_dim = load_word[kd_tree_pkg::split_dim_lsb +: kd_tree_pkg::split_dim_width];

  // write counter
  // saturates because wr_en is low once full
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_count_q <= '0;
    end else if (wr_en) begin
      node_count_q <= node_count_q + 1'b1;
    end
  end

  // node words
  // cleared on reset so an unloaded tree sends every patch down a known path
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < kd_tree_pkg::node_count; n++) begin
        nodes[n] <= '0;
      end
    end else if (wr_en) begin
      nodes[node_count_q] <= load_word;
    end
  end

  // per-level read ports
  // a word written on one edge is seen from the next cycle on
  always_comb begin
    for (int l = 0; l < kd_tree_pkg::tree_depth; l++) begin
      // index 127 is a leaf, not a stored node
      if (read_index[l] <
          kd_tree_pkg::node_index_width'(kd_tree_pkg::node_count)) begin
        read_word[l] = nodes[read_index[l]];
      end else begin
        read_word[l] = '0;
      end
    end
  end

  // stages use the split dimension as a mux select over 5 components,
  // so a stored dimension must name a real component
  a_split_dim_in_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> (int'(load_dim) < kd_tree_pkg::patch_dims)
  ) else $error("node table stored split dimension %0d", load_dim);

  // host writing into a full table
  // tolerated, the word is dropped
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    load_full |-> !load_en
  ) else $warning("node table load_en while full, word ignored");

endmodule

`default_nettype wire

/* hw/kd_tree_pkg.sv */
// k-d tree search package
// tree geometry, patch and node word widths, and node word field positions
// shared by the node table, the level stages and the top level

`default_nettype none

package kd_tree_pkg;

  // tree shape, 7 internal levels above 128 leaves
  localparam int tree_depth = 7;
  localparam int node_count = 127;
  localparam int leaf_count = 128;

  // index widths
  localparam int node_index_width = 7;
  localparam int leaf_index_width = 7;

  // patch layout
  // component d sits at bits d*component_width upward
  localparam int patch_dims      = 5;
  localparam int component_width = 11;
  localparam int patch_width     = patch_dims * component_width;

  // node word, split dimension above split value
  localparam int node_word_width = 14;
  localparam int split_value_lsb = 0;
  localparam int split_dim_lsb   = 11;
  localparam int split_dim_width = 3;

endpackage

`default_nettype wire
